//--- vlog.f
+incdir+verif
hdl/gb_bus_pkg.sv
hdl/gb_memory_map.sv
hdl/gb_work_ram.sv
hdl/gb_interrupt_regs.sv
hdl/gb_read_return.sv
hdl/gb_bus_top.sv
verif/gb_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the memory bus fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timescale 1ns/1ps -f vlog.f --top-module gb_bus_tb \
   -Mdir "$build_dir" -o gb_bus_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build exited with status $status"
   exit 1
fi

"./$build_dir/gb_bus_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" "$log_file"; then
   echo "simulation reported failures, see $log_file"
   exit 1
fi

echo "simulation finished clean"
exit 0

//--- verif/gb_bus_tests.svh
// directed tests for the memory bus fabric
// work ram and echo, boot overlay, interrupts, unmapped space, pipelined reads

task automatic test_work_ram_echo();
   logic [31:0] r;
   bus_addr_t   a;
   bus_addr_t   mirror;
   bus_data_t   got;
   int          i;
   start_test("work_ram_echo");
   for (i = 0; i < 32; i++) begin
      r      = next_random();
      a      = 16'hC000 + (r[15:0] % 16'h1E00);
      mirror = a + 16'h2000;
      // odd passes write through the echo and read the ram window
      if (i[0]) begin
         mirror = a;
         a      = a + 16'h2000;
      end
      bus_write(a, r[23:16]);
      ref_mem[wram_key(a)] = r[23:16];
      bus_read(mirror, got);
      check_data($sformatf("read 0x%h", mirror), ref_mem[wram_key(mirror)], got);
   end
   end_test();
endtask

task automatic test_boot_overlay();
   logic [31:0] r;
   bus_addr_t   a;
   bus_data_t   got;
   int          i;
   start_test("boot_overlay");
   check_bit("boot_done after reset", 1'b0, boot_done);
   for (i = 0; i < 256; i++) begin
      a = {8'h00, i[7:0]};
      bus_read(a, got);
      check_data($sformatf("boot read 0x%h", a), boot_model(a), got);
   end
   for (i = 0; i < 24; i++) begin
      r = next_random();
      a = 16'h0100 + (r[15:0] % 16'h7F00);
      bus_read(a, got);
      check_data($sformatf("cart read 0x%h", a), cart_model(a), got);
   end
   bus_write(16'hFF50, 8'h01);
   check_bit("boot_done after disable", 1'b1, boot_done);
   bus_read(16'hFF50, got);
   check_data("boot flag read", 8'h01, got);
   // with the overlay gone the cartridge shows through
   for (i = 0; i < 256; i++) begin
      a = {8'h00, i[7:0]};
      bus_read(a, got);
      check_data($sformatf("cart read 0x%h", a), cart_model(a), got);
   end
   end_test();
endtask

task automatic test_interrupts();
   bus_data_t got;
   start_test("interrupts");
   check_flags("flags after reset", 5'h00, int_flags);
   check_flags("enable after reset", 5'h00, int_enable);
   pulse_irq(1'b1, 1'b0, 1'b0);
   check_flags("vblank request", 5'h01, int_flags);
   pulse_irq(1'b0, 1'b1, 1'b0);
   check_flags("lcd request", 5'h03, int_flags);
   pulse_irq(1'b0, 1'b0, 1'b1);
   check_flags("timer request", 5'h07, int_flags);
   bus_read(16'hFF0F, got);
   check_data("flag read", 8'h07, got);
   // upper three bits of the written byte are dropped
   bus_write(16'hFF0F, 8'hFA);
   check_flags("flag write", 5'h1A, int_flags);
   bus_read(16'hFF0F, got);
   check_data("flag read after write", 8'h1A, got);
   // write and timer request in the same cycle
   @(negedge clock);
   addr      = 16'hFF0F;
   wr_data   = 8'h08;
   mem_we    = 1'b1;
   irq_timer = 1'b1;
   @(negedge clock);
   mem_we    = 1'b0;
   irq_timer = 1'b0;
   check_flags("write against request", 5'h08, int_flags);
   pulse_irq(1'b0, 1'b1, 1'b0);
   check_flags("request on top of write", 5'h0A, int_flags);
   bus_write(16'hFFFF, 8'hF5);
   check_flags("enable write", 5'h15, int_enable);
   bus_read(16'hFFFF, got);
   check_data("enable read", 8'h15, got);
   end_test();
endtask

task automatic test_unmapped_space();
   bus_addr_t holes [6];
   bus_addr_t roms [4];
   bus_data_t got;
   int        i;
   start_test("unmapped_space");
   holes = '{16'h8000, 16'hA000, 16'hFE00, 16'hFF00, 16'hFF80, 16'hFFFE};
   roms  = '{16'h0000, 16'h0010, 16'h4000, 16'h7FFF};
   bus_write(16'hC000, 8'h6D);
   ref_mem[16'hC000] = 8'h6D;
   for (i = 0; i < 6; i++) begin
      bus_write(holes[i], 8'h5A);
      bus_read(holes[i], got);
      check_data($sformatf("unmapped read 0x%h", holes[i]), 8'h00, got);
   end
   for (i = 0; i < 4; i++) begin
      bus_write(roms[i], 8'h3C);
      bus_read(roms[i], got);
      check_data($sformatf("rom read 0x%h", roms[i]), cart_model(roms[i]), got);
   end
   // 0x0000 folds onto the same ram index as 0xC000
   bus_read(16'hC000, got);
   check_data("ram after rom writes", ref_mem[16'hC000], got);
   check_bit("boot_done kept", 1'b1, boot_done);
   check_flags("flags kept", 5'h0A, int_flags);
   end_test();
endtask

task automatic test_pipelined_reads();
   logic [31:0] r;
   bus_addr_t   a;
   bus_addr_t   last_write;
   bus_data_t   expect_q;
   logic        pending;
   logic        read_back;
   int          i;
   start_test("pipelined_reads");
   for (i = 0; i < 64; i++) begin
      r = next_random();
      a = 16'hD000 + {10'd0, i[5:0]};
      bus_write(a, r[7:0]);
      ref_mem[a] = r[7:0];
   end
   pending    = 1'b0;
   read_back  = 1'b0;
   last_write = 16'hD000;
   expect_q   = 8'h00;
   for (i = 0; i < 161; i++) begin
      @(negedge clock);
      // result of the request issued one cycle ago
      check_bit("rd_valid timing", pending, rd_valid);
      if (pending) begin
         check_data("pipelined read", expect_q, rd_data);
      end
      r = next_random();
      a = 16'hD000 + {10'd0, r[21:16]};
      if (r[22]) begin
         a = a + 16'h2000;
      end
      mem_we  = 1'b0;
      mem_re  = 1'b0;
      pending = 1'b0;
      if (i == 160) begin
         read_back = 1'b0;
      end else if (read_back) begin
         addr      = last_write;
         mem_re    = 1'b1;
         expect_q  = ref_mem[wram_key(last_write)];
         pending   = 1'b1;
         read_back = 1'b0;
      end else if (r[2:0] == 3'd0) begin
         addr       = a;
         wr_data    = r[15:8];
         mem_we     = 1'b1;
         last_write = a;
         read_back  = 1'b1;
         ref_mem[wram_key(a)] = r[15:8];
      end else begin
         addr     = a;
         mem_re   = 1'b1;
         expect_q = ref_mem[wram_key(a)];
         pending  = 1'b1;
      end
   end
   end_test();
endtask

//--- verif/gb_bus_tb.sv
// testbench for the memory bus fabric
// clock, reset, rom models, work ram reference model
// bus tasks, compare tasks and the closing summary
`timescale 1ns/1ps

module gb_bus_tb
   import gb_bus_pkg::*;
();

   localparam int read_timeout = 20;

   logic      clock;
   logic      reset;
   bus_addr_t addr;
   bus_data_t wr_data;
   logic      mem_we;
   logic      mem_re;
   bus_data_t boot_data;
   bus_data_t cart_data;
   logic      irq_vblank;
   logic      irq_lcd;
   logic      irq_timer;
   bus_data_t rd_data;
   logic      rd_valid;
   int_bits_t int_flags;
   int_bits_t int_enable;
   logic      boot_done;

   // indexed by the work ram address with the echo folded down
   bus_data_t   ref_mem [65536];
   logic [31:0] rng_state;
   string       current_test;
   int          test_errors;
   int          error_count;
   int          tests_run;
   int          tests_bad;

   gb_bus_top #(
      .wram_addr_width (13)
   ) u_dut (
      .clock      (clock),
      .reset      (reset),
      .addr       (addr),
      .wr_data    (wr_data),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .boot_data  (boot_data),
      .cart_data  (cart_data),
      .irq_vblank (irq_vblank),
      .irq_lcd    (irq_lcd),
      .irq_timer  (irq_timer),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .int_flags  (int_flags),
      .int_enable (int_enable),
      .boot_done  (boot_done)
   );

   always #2 clock = ~clock;

   function automatic bus_data_t boot_model(input bus_addr_t a);
      return a[7:0] ^ 8'hA5;
   endfunction

   function automatic bus_data_t cart_model(input bus_addr_t a);
      return a[15:8] + a[7:0];
   endfunction

   // rom bytes follow the address combinationally
   assign boot_data = boot_model(addr);
   assign cart_data = cart_model(addr);

   function automatic bus_addr_t wram_key(input bus_addr_t a);
      // echo bytes sit 0x2000 above the ram bytes they mirror
      if (a >= 16'hE000) begin
         return a - 16'h2000;
      end
      return a;
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_random();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   task automatic check_data(input string what, input bus_data_t expected,
                             input bus_data_t actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: %s expected 0x%h, actual 0x%h",
                  current_test, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_flags(input string what, input int_bits_t expected,
                              input int_bits_t actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: %s expected 0x%h, actual 0x%h",
                  current_test, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: %s expected %b, actual %b",
                  current_test, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      current_test = name;
      test_errors  = 0;
   endtask

   task automatic end_test();
      tests_run++;
      error_count += test_errors;
      if (test_errors > 0) begin
         tests_bad++;
      end
      $display("test %s finished with %0d errors", current_test, test_errors);
   endtask

   // the byte lands on the edge that closes the write cycle
   task automatic bus_write(input bus_addr_t a, input bus_data_t d);
      @(negedge clock);
      addr    = a;
      wr_data = d;
      mem_re  = 1'b0;
      mem_we  = 1'b1;
      @(negedge clock);
      mem_we = 1'b0;
   endtask

   task automatic bus_read(input bus_addr_t a, output bus_data_t data);
      int waited;
      @(negedge clock);
      addr   = a;
      mem_we = 1'b0;
      mem_re = 1'b1;
      waited = 0;
      data   = 8'h00;
      do begin
         @(negedge clock);
         mem_re = 1'b0;
         waited++;
      end while (!rd_valid && waited < read_timeout);
      if (rd_valid) begin
         data = rd_data;
      end else begin
         $display("%s: no read data came back within %0d cycles for address 0x%h",
                  current_test, read_timeout, a);
         test_errors++;
      end
   endtask

   task automatic pulse_irq(input logic vblank, input logic lcd, input logic timer);
      @(negedge clock);
      irq_vblank = vblank;
      irq_lcd    = lcd;
      irq_timer  = timer;
      @(negedge clock);
      irq_vblank = 1'b0;
      irq_lcd    = 1'b0;
      irq_timer  = 1'b0;
   endtask

   `include "gb_bus_tests.svh"

   initial begin
      clock       = 1'b0;
      reset       = 1'b1;
      addr        = '0;
      wr_data     = '0;
      mem_we      = 1'b0;
      mem_re      = 1'b0;
      irq_vblank  = 1'b0;
      irq_lcd     = 1'b0;
      irq_timer   = 1'b0;
      rng_state   = 32'd77186;
      error_count = 0;
      tests_run   = 0;
      tests_bad   = 0;
      repeat (16) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      // boot overlay must run before anything touches 0xFF50
      test_work_ram_echo();
      test_boot_overlay();
      test_interrupts();
      test_unmapped_space();
      test_pipelined_reads();
      $display("summary: %0d tests run, %0d with errors, %0d errors in total",
               tests_run, tests_bad, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- hdl/gb_bus_top.sv
// top level of the memory bus fabric
// decoder, work ram, interrupt registers and read return
`timescale 1ns/1ps

module gb_bus_top
   import gb_bus_pkg::*;
#(
   parameter int wram_addr_width = 13
) (
   input  logic      clock,
   input  logic      reset,
   input  bus_addr_t addr,
   input  bus_data_t wr_data,
   input  logic      mem_we,
   input  logic      mem_re,
   input  bus_data_t boot_data,
   input  bus_data_t cart_data,
   input  logic      irq_vblank,
   input  logic      irq_lcd,
   input  logic      irq_timer,
   output bus_data_t rd_data,
   output logic      rd_valid,
   output int_bits_t int_flags,
   output int_bits_t int_enable,
   output logic      boot_done
);

   region_t     region;
   wram_index_t wram_index;
   bus_data_t   boot_flag_byte;
   bus_data_t   ram_q;
   logic        wram_we;

   assign wram_we = mem_we && (region == region_wram);

   gb_memory_map #(
      .wram_addr_width (wram_addr_width)
   ) u_memory_map (
      .clock          (clock),
      .reset          (reset),
      .addr           (addr),
      .wr_data        (wr_data),
      .mem_we         (mem_we),
      .region         (region),
      .wram_index     (wram_index),
      .boot_flag_byte (boot_flag_byte),
      .boot_done      (boot_done)
   );

   gb_work_ram #(
      .wram_addr_width (wram_addr_width)
   ) u_work_ram (
      .clock      (clock),
      .wram_index (wram_index),
      .wr_data    (wr_data),
      .we         (wram_we),
      .ram_q      (ram_q)
   );

   gb_interrupt_regs u_interrupt_regs (
      .clock      (clock),
      .reset      (reset),
      .region     (region),
      .mem_we     (mem_we),
      .wr_data    (wr_data),
      .irq_vblank (irq_vblank),
      .irq_lcd    (irq_lcd),
      .irq_timer  (irq_timer),
      .int_flags  (int_flags),
      .int_enable (int_enable)
   );

   gb_read_return u_read_return (
      .clock          (clock),
      .reset          (reset),
      .region         (region),
      .mem_re         (mem_re),
      .boot_data      (boot_data),
      .cart_data      (cart_data),
      .boot_flag_byte (boot_flag_byte),
      .int_flags      (int_flags),
      .int_enable     (int_enable),
      .ram_q          (ram_q),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid)
   );

endmodule

//--- hdl/gb_read_return.sv
// read data return path
// captures the source byte in the request cycle
// selects ram or captured byte one cycle later with a valid pulse
`timescale 1ns/1ps

module gb_read_return
   import gb_bus_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  region_t   region,
   input  logic      mem_re,
   input  bus_data_t boot_data,
   input  bus_data_t cart_data,
   input  bus_data_t boot_flag_byte,
   input  int_bits_t int_flags,
   input  int_bits_t int_enable,
   input  bus_data_t ram_q,
   output bus_data_t rd_data,
   output logic      rd_valid
);

   bus_data_t source_byte;
   bus_data_t captured;
   region_t   region_q;
   logic      valid_q;

   // unmapped space and the ram region give zero here
   always_comb begin
      case (region)
         region_boot:       source_byte = boot_data;
         region_cart:       source_byte = cart_data;
         region_boot_flag:  source_byte = boot_flag_byte;
         region_int_flag:   source_byte = {3'b000, int_flags};
         region_int_enable: source_byte = {3'b000, int_enable};
         default:           source_byte = '0;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         valid_q  <= 1'b0;
         region_q <= region_none;
      end else begin
         valid_q <= mem_re;
         if (mem_re) begin
            region_q <= region;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (mem_re) begin
         captured <= source_byte;
      end
   end

   // ram output is already registered by the ram itself
   assign rd_data  = (region_q == region_wram) ? ram_q : captured;
   assign rd_valid = valid_q;

endmodule

//--- hdl/gb_interrupt_regs.sv
// interrupt flag and interrupt enable registers
// request pins merge into the flags and a bus write wins
`timescale 1ns/1ps

module gb_interrupt_regs
   import gb_bus_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  region_t   region,
   input  logic      mem_we,
   input  bus_data_t wr_data,
   input  logic      irq_vblank,
   input  logic      irq_lcd,
   input  logic      irq_timer,
   output int_bits_t int_flags,
   output int_bits_t int_enable
);

   int_bits_t req_bits;
   int_bits_t flags;
   int_bits_t enable;
   logic      flag_write;
   logic      enable_write;

   // serial and joypad have no request pin here
   always_comb begin
      req_bits             = '0;
      req_bits[int_vblank] = irq_vblank;
      req_bits[int_lcd]    = irq_lcd;
      req_bits[int_timer]  = irq_timer;
   end

   assign flag_write   = mem_we && (region == region_int_flag);
   assign enable_write = mem_we && (region == region_int_enable);

   // flags are sticky until the processor writes them
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else if (flag_write) begin
         flags <= wr_data[4:0];
      end else begin
         flags <= flags | req_bits;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         enable <= '0;
      end else if (enable_write) begin
         enable <= wr_data[4:0];
      end
   end

   assign int_flags  = flags;
   assign int_enable = enable;

endmodule

//--- hdl/gb_work_ram.sv
// single-port byte-wide work ram
// registered read with write-first on the same index
`timescale 1ns/1ps

module gb_work_ram
   import gb_bus_pkg::*;
#(
   parameter int wram_addr_width = 13
) (
   input  logic        clock,
   input  wram_index_t wram_index,
   input  bus_data_t   wr_data,
   input  logic        we,
   output bus_data_t   ram_q
);

   localparam int depth = 2 ** wram_addr_width;

   bus_data_t mem [depth];

   logic [wram_addr_width-1:0] index;

   assign index = wram_index[wram_addr_width-1:0];

   // output follows the index every cycle
   always_ff @(posedge clock) begin
      if (we) begin
         mem[index] <= wr_data;
         // new byte shows on the output at once
         ram_q <= wr_data;
      end else begin
         ram_q <= mem[index];
      end
   end

endmodule

//--- hdl/gb_memory_map.sv
// address decoder for the processor bus
// boot-disable register that controls the boot rom overlay
// work ram index for the ram and echo windows
`timescale 1ns/1ps

module gb_memory_map
   import gb_bus_pkg::*;
#(
   parameter int wram_addr_width = 13
) (
   input  logic        clock,
   input  logic        reset,
   input  bus_addr_t   addr,
   input  bus_data_t   wr_data,
   input  logic        mem_we,
   output region_t     region,
   output wram_index_t wram_index,
   output bus_data_t   boot_flag_byte,
   output logic        boot_done
);

   bus_data_t boot_flag;
   logic      in_wram;
   logic      in_echo;
   bus_addr_t wram_offset;

   assign in_wram = (addr >= wram_start) && (addr <= wram_end);
   assign in_echo = (addr >= echo_start) && (addr <= echo_end);

   // overlay only while boot flag bit 0 is clear
   always_comb begin
      region = region_none;
      if ((addr <= boot_rom_end) && !boot_flag[0]) begin
         region = region_boot;
      end else if (addr <= cart_rom_end) begin
         region = region_cart;
      end else if (in_wram || in_echo) begin
         region = region_wram;
      end else if (addr == addr_boot_flag) begin
         region = region_boot_flag;
      end else if (addr == addr_int_flag) begin
         region = region_int_flag;
      end else if (addr == addr_int_enable) begin
         region = region_int_enable;
      end
   end

   // echo window folds onto the same ram bytes
   always_comb begin
      if (in_echo) begin
         wram_offset = addr - echo_start;
      end else begin
         wram_offset = addr - wram_start;
      end
   end

   // a narrower ram just aliases inside its window
   assign wram_index = wram_index_t'(wram_offset[wram_addr_width-1:0]);

   // once boot flag bit 0 is set the cartridge shows at 0x0000
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_flag <= '0;
      end else if (mem_we && (region == region_boot_flag)) begin
         boot_flag <= wr_data;
      end
   end

   assign boot_flag_byte = boot_flag;
   assign boot_done      = boot_flag[0];

endmodule

//--- hdl/gb_bus_pkg.sv
// shared bus types for the memory fabric
// region enum used by the decoder and read return
// memory map boundaries and interrupt bit positions
package gb_bus_pkg;

   typedef logic [15:0] bus_addr_t;
   typedef logic [7:0]  bus_data_t;
   typedef logic [12:0] wram_index_t;

   // bit 0 vblank, 1 lcd status, 2 timer, 3 serial, 4 joypad
   typedef logic [4:0]  int_bits_t;

   typedef enum logic [2:0] {
      region_none,
      region_boot,
      region_cart,
      region_wram,
      region_boot_flag,
      region_int_flag,
      region_int_enable
   } region_t;

   // rom space
   localparam bus_addr_t boot_rom_end    = 16'h00FF;
   localparam bus_addr_t cart_rom_end    = 16'h7FFF;

   // work ram and its echo
   localparam bus_addr_t wram_start      = 16'hC000;
   localparam bus_addr_t wram_end        = 16'hDFFF;
   localparam bus_addr_t echo_start      = 16'hE000;
   localparam bus_addr_t echo_end        = 16'hFDFF;

   // single byte registers
   localparam bus_addr_t addr_int_flag   = 16'hFF0F;
   localparam bus_addr_t addr_boot_flag  = 16'hFF50;
   localparam bus_addr_t addr_int_enable = 16'hFFFF;

   // request pin positions in the flag register
   localparam int int_vblank = 0;
   localparam int int_lcd    = 1;
   localparam int int_timer  = 2;

endpackage
